//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = tb_mmu
FILELIST   = src.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/mmu_consts.svh
// MMU constants
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address and field widths
`define MMU_VLEN   32
`define MMU_PLEN   34
`define MMU_PPNW   22
`define MMU_VPNW   20
`define MMU_VPN0W  10
`define MMU_ASIDW  9
`define MMU_OFFW   12
`define MMU_PRIVW  2
`define MMU_CAUSEW 4

// tlb sizes
`define MMU_ITLB_ENTRIES 2
`define MMU_DTLB_ENTRIES 4

// privilege levels
`define MMU_PRIV_U 2'b00
`define MMU_PRIV_S 2'b01

// exception causes
`define MMU_CAUSE_LD_MISALIGNED 4'd4
`define MMU_CAUSE_ST_MISALIGNED 4'd6
`define MMU_CAUSE_INSTR_PF      4'd12
`define MMU_CAUSE_LD_PF         4'd13
`define MMU_CAUSE_ST_PF         4'd15

`endif

//--- hdl/mmu_fetch_xlate.sv
// Fetch address translation
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module mmu_fetch_xlate (
  input  mmu_pkg::fetch_req_t fetch_req_i,
  input  logic                enable_translation_i,
  input  mmu_pkg::priv_t      priv_lvl_i,
  input  logic                itlb_hit_i,
  input  mmu_pkg::pte_t       itlb_content_i,
  input  logic                itlb_is_page_i,
  output mmu_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                itlb_miss_o
);

  logic iaccess_err;

  // u pages are for user mode only and s mode may not execute them
  assign iaccess_err = ((priv_lvl_i == `MMU_PRIV_U) && !itlb_content_i.u)
                    || ((priv_lvl_i == `MMU_PRIV_S) && itlb_content_i.u);

  always_comb begin
    // bare mode
    fetch_rsp_o.valid     = fetch_req_i.req;
    fetch_rsp_o.paddr     = mmu_pkg::paddr_t'(fetch_req_i.vaddr);
    fetch_rsp_o.exception = '0;
    itlb_miss_o           = 1'b0;

    if (enable_translation_i) begin
      fetch_rsp_o.valid = 1'b0;
      fetch_rsp_o.paddr = {itlb_content_i.ppn, fetch_req_i.vaddr[`MMU_OFFW-1:0]};
      // 4 MiB page takes vpn[0] straight from the address
      if (itlb_is_page_i) begin
        fetch_rsp_o.paddr[`MMU_OFFW +: `MMU_VPN0W] =
          fetch_req_i.vaddr[`MMU_OFFW +: `MMU_VPN0W];
      end

      if (itlb_hit_i) begin
        fetch_rsp_o.valid = fetch_req_i.req;
        if (fetch_req_i.req && iaccess_err) begin
          fetch_rsp_o.exception.valid = 1'b1;
          fetch_rsp_o.exception.cause = `MMU_CAUSE_INSTR_PF;
          fetch_rsp_o.exception.tval  = fetch_req_i.vaddr;
        end
      end else begin
        // no entry yet so wait for a refill
        itlb_miss_o = fetch_req_i.req;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmu_lsu_xlate.sv
// Load/store address translation
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module mmu_lsu_xlate (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_ld_st_translation_i,
  input  mmu_pkg::priv_t      ld_st_priv_lvl_i,
  input  logic                sum_i,
  input  logic                lsu_req_i,
  input  mmu_pkg::vaddr_t     lsu_vaddr_i,
  input  logic                lsu_is_store_i,
  input  logic                lsu_misaligned_i,
  input  logic                dtlb_hit_i,
  input  mmu_pkg::pte_t       dtlb_content_i,
  input  logic                dtlb_is_page_i,
  output logic                lsu_dtlb_hit_o,
  output mmu_pkg::ppn_t       lsu_dtlb_ppn_o,
  output logic                dtlb_miss_o,
  output logic                lsu_valid_o,
  output mmu_pkg::paddr_t     lsu_paddr_o,
  output mmu_pkg::exception_t lsu_exception_o
);

  // request stage
  logic            lsu_req_q;
  logic            misaligned_q;
  logic            dtlb_hit_q;
  mmu_pkg::vaddr_t lsu_vaddr_q;
  logic            lsu_is_store_q;
  mmu_pkg::pte_t   dtlb_pte_q;
  logic            dtlb_is_page_q;

  logic daccess_err;

  // --------------------
  // cycle 0
  // --------------------
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;
  assign dtlb_miss_o    = en_ld_st_translation_i && lsu_req_i && !dtlb_hit_i;

  always_comb begin
    lsu_dtlb_ppn_o = mmu_pkg::ppn_t'(lsu_vaddr_i[`MMU_VLEN-1:`MMU_OFFW]);
    if (en_ld_st_translation_i) begin
      lsu_dtlb_ppn_o = dtlb_content_i.ppn;
      if (dtlb_is_page_i) begin
        lsu_dtlb_ppn_o[`MMU_VPN0W-1:0] = lsu_vaddr_i[`MMU_OFFW +: `MMU_VPN0W];
      end
    end
  end

  // --------------------
  // stage registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lsu_req_q    <= 1'b0;
      misaligned_q <= 1'b0;
      dtlb_hit_q   <= 1'b0;
    end else begin
      lsu_req_q    <= lsu_req_i;
      misaligned_q <= lsu_misaligned_i && lsu_req_i;
      dtlb_hit_q   <= dtlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    lsu_vaddr_q    <= lsu_vaddr_i;
    lsu_is_store_q <= lsu_is_store_i;
    dtlb_pte_q     <= dtlb_content_i;
    dtlb_is_page_q <= dtlb_is_page_i;
  end

  // --------------------
  // cycle 1
  // --------------------
  // s mode needs sum to reach user pages, u mode only reaches user pages
  assign daccess_err = ((ld_st_priv_lvl_i == `MMU_PRIV_S) && !sum_i && dtlb_pte_q.u)
                    || ((ld_st_priv_lvl_i == `MMU_PRIV_U) && !dtlb_pte_q.u);

  always_comb begin
    lsu_valid_o     = lsu_req_q;
    lsu_paddr_o     = mmu_pkg::paddr_t'(lsu_vaddr_q);
    lsu_exception_o = '0;

    if (misaligned_q) begin
      // misaligned wins over any translation result
      lsu_exception_o.valid = 1'b1;
      lsu_exception_o.cause = lsu_is_store_q ? `MMU_CAUSE_ST_MISALIGNED
                                             : `MMU_CAUSE_LD_MISALIGNED;
      lsu_exception_o.tval  = lsu_vaddr_q;
    end else if (en_ld_st_translation_i) begin
      lsu_valid_o = 1'b0;
      lsu_paddr_o = {dtlb_pte_q.ppn, lsu_vaddr_q[`MMU_OFFW-1:0]};
      if (dtlb_is_page_q) begin
        lsu_paddr_o[`MMU_OFFW +: `MMU_VPN0W] = lsu_vaddr_q[`MMU_OFFW +: `MMU_VPN0W];
      end

      if (dtlb_hit_q && lsu_req_q) begin
        lsu_valid_o = 1'b1;
        if (lsu_is_store_q) begin
          // stores also need write permission and a dirty page
          if (daccess_err || !dtlb_pte_q.w || !dtlb_pte_q.d) begin
            lsu_exception_o.valid = 1'b1;
            lsu_exception_o.cause = `MMU_CAUSE_ST_PF;
            lsu_exception_o.tval  = lsu_vaddr_q;
          end
        end else if (daccess_err) begin
          lsu_exception_o.valid = 1'b1;
          lsu_exception_o.cause = `MMU_CAUSE_LD_PF;
          lsu_exception_o.tval  = lsu_vaddr_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmu_pkg.sv
// MMU shared types
`default_nettype none

`include "mmu_consts.svh"

package mmu_pkg;

  // --------------------
  // plain vectors
  // --------------------
  typedef logic [`MMU_VLEN-1:0]   vaddr_t;
  typedef logic [`MMU_PLEN-1:0]   paddr_t;
  typedef logic [`MMU_PPNW-1:0]   ppn_t;
  typedef logic [`MMU_VPNW-1:0]   vpn_t;
  typedef logic [`MMU_ASIDW-1:0]  asid_t;
  typedef logic [`MMU_PRIVW-1:0]  priv_t;
  typedef logic [`MMU_CAUSEW-1:0] cause_t;

  // --------------------
  // structs
  // --------------------
  // sv32 leaf entry without the rsw field
  typedef struct packed {
    ppn_t ppn;
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_t;

  // one refill write, is_page marks a 4 MiB page
  typedef struct packed {
    logic  valid;
    logic  is_page;
    vpn_t  vpn;
    asid_t asid;
    pte_t  content;
  } tlb_update_t;

  typedef struct packed {
    logic   valid;
    cause_t cause;
    vaddr_t tval;
  } exception_t;

  typedef struct packed {
    logic   req;
    vaddr_t vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic       valid;
    paddr_t     paddr;
    exception_t exception;
  } fetch_rsp_t;

endpackage

`default_nettype wire

//--- hdl/mmu_tlb.sv
// Fully associative TLB
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module mmu_tlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  mmu_pkg::tlb_update_t update_i,
  input  logic                 lu_access_i,
  input  mmu_pkg::asid_t       lu_asid_i,
  input  mmu_pkg::vaddr_t      lu_vaddr_i,
  output logic                 lu_hit_o,
  output mmu_pkg::pte_t        lu_content_o,
  output logic                 lu_is_page_o
);

  localparam int unsigned PtrW = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  // tag and content storage
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] is_page_q;
  mmu_pkg::vpn_t          vpn_q     [TLB_ENTRIES];
  mmu_pkg::asid_t         asid_q    [TLB_ENTRIES];
  mmu_pkg::pte_t          content_q [TLB_ENTRIES];

  // round robin victim
  logic [PtrW-1:0] repl_q;

  mmu_pkg::vpn_t          lu_vpn;
  logic [TLB_ENTRIES-1:0] match;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_OFFW];

  // --------------------
  // lookup
  // --------------------
  always_comb begin
    for (int i = 0; i < int'(TLB_ENTRIES); i++) begin
      // superpages only compare vpn[1]
      match[i] = valid_q[i]
               && (vpn_q[i][`MMU_VPNW-1:`MMU_VPN0W] == lu_vpn[`MMU_VPNW-1:`MMU_VPN0W])
               && (is_page_q[i] || (vpn_q[i][`MMU_VPN0W-1:0] == lu_vpn[`MMU_VPN0W-1:0]))
               && ((asid_q[i] == lu_asid_i) || content_q[i].g);
    end
  end

  // walk downwards so the lowest matching index is the last one written
  always_comb begin
    lu_hit_o     = 1'b0;
    lu_content_o = '0;
    lu_is_page_o = 1'b0;
    for (int i = int'(TLB_ENTRIES) - 1; i >= 0; i--) begin
      if (match[i]) begin
        lu_hit_o     = lu_access_i;
        lu_content_o = content_q[i];
        lu_is_page_o = is_page_q[i];
      end
    end
  end

  // --------------------
  // refill and flush
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      repl_q  <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      repl_q  <= '0;
    end else if (update_i.valid) begin
      valid_q[repl_q] <= 1'b1;
      if (repl_q == PtrW'(TLB_ENTRIES - 1)) begin
        repl_q <= '0;
      end else begin
        repl_q <= repl_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      is_page_q[repl_q] <= update_i.is_page;
      vpn_q[repl_q]     <= update_i.vpn;
      asid_q[repl_q]    <= update_i.asid;
      content_q[repl_q] <= update_i.content;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mmu_top.sv
// Sv32 MMU top level
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module mmu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_tlb_i,
  input  logic                 enable_translation_i,
  input  logic                 en_ld_st_translation_i,
  input  mmu_pkg::priv_t       priv_lvl_i,
  input  mmu_pkg::priv_t       ld_st_priv_lvl_i,
  input  logic                 sum_i,
  input  mmu_pkg::asid_t       asid_i,
  // fetch port
  input  mmu_pkg::fetch_req_t  fetch_req_i,
  output mmu_pkg::fetch_rsp_t  fetch_rsp_o,
  // load/store port
  input  logic                 lsu_req_i,
  input  mmu_pkg::vaddr_t      lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic                 lsu_misaligned_i,
  output logic                 lsu_dtlb_hit_o,
  output mmu_pkg::ppn_t        lsu_dtlb_ppn_o,
  output logic                 lsu_valid_o,
  output mmu_pkg::paddr_t      lsu_paddr_o,
  output mmu_pkg::exception_t  lsu_exception_o,
  // refills
  input  mmu_pkg::tlb_update_t itlb_update_i,
  input  mmu_pkg::tlb_update_t dtlb_update_i,
  // performance counters
  output logic                 itlb_miss_o,
  output logic                 dtlb_miss_o
);

  logic          itlb_hit;
  mmu_pkg::pte_t itlb_content;
  logic          itlb_is_page;
  logic          dtlb_hit;
  mmu_pkg::pte_t dtlb_content;
  logic          dtlb_is_page;

  // --------------------
  // instruction side
  // --------------------
  mmu_tlb #(
    .TLB_ENTRIES (`MMU_ITLB_ENTRIES)
  ) i_itlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_tlb_i),
    .update_i     (itlb_update_i),
    .lu_access_i  (fetch_req_i.req),
    .lu_asid_i    (asid_i),
    .lu_vaddr_i   (fetch_req_i.vaddr),
    .lu_hit_o     (itlb_hit),
    .lu_content_o (itlb_content),
    .lu_is_page_o (itlb_is_page)
  );

  mmu_fetch_xlate i_fetch_xlate (
    .fetch_req_i          (fetch_req_i),
    .enable_translation_i (enable_translation_i),
    .priv_lvl_i           (priv_lvl_i),
    .itlb_hit_i           (itlb_hit),
    .itlb_content_i       (itlb_content),
    .itlb_is_page_i       (itlb_is_page),
    .fetch_rsp_o          (fetch_rsp_o),
    .itlb_miss_o          (itlb_miss_o)
  );

  // --------------------
  // data side
  // --------------------
  mmu_tlb #(
    .TLB_ENTRIES (`MMU_DTLB_ENTRIES)
  ) i_dtlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_tlb_i),
    .update_i     (dtlb_update_i),
    .lu_access_i  (lsu_req_i),
    .lu_asid_i    (asid_i),
    .lu_vaddr_i   (lsu_vaddr_i),
    .lu_hit_o     (dtlb_hit),
    .lu_content_o (dtlb_content),
    .lu_is_page_o (dtlb_is_page)
  );

  mmu_lsu_xlate i_lsu_xlate (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .lsu_misaligned_i       (lsu_misaligned_i),
    .dtlb_hit_i             (dtlb_hit),
    .dtlb_content_i         (dtlb_content),
    .dtlb_is_page_i         (dtlb_is_page),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_paddr_o            (lsu_paddr_o),
    .lsu_exception_o        (lsu_exception_o)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/mmu_tlb.sv
hdl/mmu_fetch_xlate.sv
hdl/mmu_lsu_xlate.sv
hdl/mmu_top.sv
testbench/tb_mmu.sv

//--- testbench/tb_mmu.sv
// MMU testbench
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module tb_mmu;

  typedef struct packed {
    logic          hit;
    logic          is_page;
    mmu_pkg::pte_t pte;
  } lookup_t;

  // one data request waiting for its cycle-1 answer
  typedef struct packed {
    logic            req;
    logic            mis;
    logic            store;
    logic            en;
    logic            sum;
    mmu_pkg::priv_t  priv;
    mmu_pkg::vaddr_t va;
    lookup_t         lk;
  } pend_t;

  logic clk_i, rst_ni, flush_tlb_i, enable_translation_i, en_ld_st_translation_i, sum_i;
  mmu_pkg::priv_t       priv_lvl_i, ld_st_priv_lvl_i;
  mmu_pkg::asid_t       asid_i;
  mmu_pkg::fetch_req_t  fetch_req_i;
  mmu_pkg::fetch_rsp_t  fetch_rsp_o;
  logic                 lsu_req_i, lsu_is_store_i, lsu_misaligned_i;
  mmu_pkg::vaddr_t      lsu_vaddr_i;
  logic                 lsu_dtlb_hit_o, lsu_valid_o, itlb_miss_o, dtlb_miss_o;
  mmu_pkg::ppn_t        lsu_dtlb_ppn_o;
  mmu_pkg::paddr_t      lsu_paddr_o;
  mmu_pkg::exception_t  lsu_exception_o;
  mmu_pkg::tlb_update_t itlb_update_i, dtlb_update_i;

  // reference TLBs, index 0 is the ITLB and 1 the DTLB
  logic            m_valid [2][4];
  logic            m_page  [2][4];
  mmu_pkg::vpn_t   m_vpn   [2][4];
  mmu_pkg::asid_t  m_asid  [2][4];
  mmu_pkg::pte_t   m_pte   [2][4];
  int              m_ptr   [2];
  int              m_size  [2];
  pend_t           pend;
  logic            last_dtlb_hit;
  int              errors, checks, timeouts;

  mmu_top i_dut (.*);

  always #10 clk_i = ~clk_i;

  // --------------------
  // reference model
  // --------------------
  function automatic lookup_t lookup(int t, mmu_pkg::vaddr_t va);
    lookup_t r;
    r = '0;
    for (int i = 0; i < m_size[t]; i++) begin
      if (!r.hit && m_valid[t][i] && (m_vpn[t][i][19:10] == va[31:22])
          && (m_page[t][i] || (m_vpn[t][i][9:0] == va[21:12]))
          && ((m_asid[t][i] == asid_i) || m_pte[t][i].g)) begin
        r.hit     = 1'b1;
        r.is_page = m_page[t][i];
        r.pte     = m_pte[t][i];
      end
    end
    return r;
  endfunction

  function automatic mmu_pkg::paddr_t xlate(mmu_pkg::ppn_t ppn, logic page,
                                            mmu_pkg::vaddr_t va);
    mmu_pkg::paddr_t pa;
    pa = {ppn, va[11:0]};
    // 4 MiB pages keep vpn[0] from the address
    if (page) pa[21:12] = va[21:12];
    return pa;
  endfunction

  function automatic logic user_fault(mmu_pkg::priv_t priv, logic sum, logic u);
    return ((priv == `MMU_PRIV_U) && !u) || ((priv == `MMU_PRIV_S) && u && !sum);
  endfunction

  task automatic model_refill(int t, mmu_pkg::tlb_update_t u);
    m_valid[t][m_ptr[t]] = 1'b1;
    m_page[t][m_ptr[t]]  = u.is_page;
    m_vpn[t][m_ptr[t]]   = u.vpn;
    m_asid[t][m_ptr[t]]  = u.asid;
    m_pte[t][m_ptr[t]]   = u.content;
    m_ptr[t] = (m_ptr[t] + 1) % m_size[t];
  endtask

  task automatic model_flush();
    for (int t = 0; t < 2; t++) begin
      m_ptr[t] = 0;
      for (int i = 0; i < 4; i++) m_valid[t][i] = 1'b0;
    end
  endtask

  // --------------------
  // checks
  // --------------------
  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("Error %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_fetch();
    lookup_t         fl;
    logic            v, e;
    mmu_pkg::paddr_t pa;
    fl = lookup(0, fetch_req_i.vaddr);
    if (enable_translation_i) begin
      v  = fetch_req_i.req && fl.hit;
      pa = xlate(fl.pte.ppn, fl.is_page, fetch_req_i.vaddr);
      e  = v && user_fault(priv_lvl_i, 1'b0, fl.pte.u);
    end else begin
      v  = fetch_req_i.req;
      pa = {2'b00, fetch_req_i.vaddr};
      e  = 1'b0;
    end
    check_value("fetch_rsp_o.valid", 64'(v), 64'(fetch_rsp_o.valid));
    check_value("itlb_miss_o", 64'(enable_translation_i && fetch_req_i.req && !fl.hit),
                64'(itlb_miss_o));
    if (v) check_value("fetch_rsp_o.paddr", 64'(pa), 64'(fetch_rsp_o.paddr));
    check_value("fetch_rsp_o.exception.valid", 64'(e), 64'(fetch_rsp_o.exception.valid));
    if (e) begin
      check_value("fetch_rsp_o.exception.cause", 64'(`MMU_CAUSE_INSTR_PF),
                  64'(fetch_rsp_o.exception.cause));
      check_value("fetch_rsp_o.exception.tval", 64'(fetch_req_i.vaddr),
                  64'(fetch_rsp_o.exception.tval));
    end
  endtask

  task automatic check_lsu_req(lookup_t dl);
    logic            en, hit;
    mmu_pkg::paddr_t pa;
    en  = en_ld_st_translation_i;
    hit = en ? (lsu_req_i && dl.hit) : 1'b1;
    check_value("lsu_dtlb_hit_o", 64'(hit), 64'(lsu_dtlb_hit_o));
    check_value("dtlb_miss_o", 64'(en && lsu_req_i && !dl.hit), 64'(dtlb_miss_o));
    if (lsu_req_i && hit) begin
      pa = en ? xlate(dl.pte.ppn, dl.is_page, lsu_vaddr_i) : {2'b00, lsu_vaddr_i};
      check_value("lsu_dtlb_ppn_o", 64'(pa[33:12]), 64'(lsu_dtlb_ppn_o));
    end
  endtask

  task automatic check_lsu_rsp();
    logic            v, e, fault, mis;
    mmu_pkg::cause_t c;
    mmu_pkg::paddr_t pa;
    e   = 1'b0;
    c   = '0;
    mis = pend.req && pend.mis;
    pa  = pend.en ? xlate(pend.lk.pte.ppn, pend.lk.is_page, pend.va) : {2'b00, pend.va};
    if (mis) begin
      v = 1'b1;
      e = 1'b1;
      c = pend.store ? `MMU_CAUSE_ST_MISALIGNED : `MMU_CAUSE_LD_MISALIGNED;
    end else if (!pend.en) begin
      v = pend.req;
    end else begin
      v     = pend.req && pend.lk.hit;
      fault = user_fault(pend.priv, pend.sum, pend.lk.pte.u);
      // stores also need a writable, dirty page
      if (pend.store) fault = fault || !pend.lk.pte.w || !pend.lk.pte.d;
      e = v && fault;
      c = pend.store ? `MMU_CAUSE_ST_PF : `MMU_CAUSE_LD_PF;
    end
    check_value("lsu_valid_o", 64'(v), 64'(lsu_valid_o));
    if (v && !mis) check_value("lsu_paddr_o", 64'(pa), 64'(lsu_paddr_o));
    check_value("lsu_exception_o.valid", 64'(e), 64'(lsu_exception_o.valid));
    if (e) begin
      check_value("lsu_exception_o.cause", 64'(c), 64'(lsu_exception_o.cause));
      check_value("lsu_exception_o.tval", 64'(pend.va), 64'(lsu_exception_o.tval));
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  // check mid-cycle, then move the model across the rising edge
  task automatic step();
    lookup_t dl;
    @(negedge clk_i);
    check_fetch();
    check_lsu_rsp();
    dl = lookup(1, lsu_vaddr_i);
    check_lsu_req(dl);
    last_dtlb_hit = lsu_dtlb_hit_o;
    @(posedge clk_i);
    pend.req   = lsu_req_i;
    pend.mis   = lsu_misaligned_i;
    pend.store = lsu_is_store_i;
    pend.en    = en_ld_st_translation_i;
    pend.sum   = sum_i;
    pend.priv  = ld_st_priv_lvl_i;
    pend.va    = lsu_vaddr_i;
    pend.lk    = dl;
    if (flush_tlb_i) begin
      model_flush();
    end else begin
      if (itlb_update_i.valid) model_refill(0, itlb_update_i);
      if (dtlb_update_i.valid) model_refill(1, dtlb_update_i);
    end
    #2;
  endtask

  task automatic idle();
    fetch_req_i      = '0;
    lsu_req_i        = 1'b0;
    lsu_vaddr_i      = '0;
    lsu_is_store_i   = 1'b0;
    lsu_misaligned_i = 1'b0;
    flush_tlb_i      = 1'b0;
    itlb_update_i    = '0;
    dtlb_update_i    = '0;
  endtask

  // levels only change behind an idle cycle so no request sees two settings
  task automatic set_levels(logic en_f, logic en_ls, mmu_pkg::priv_t pf,
                            mmu_pkg::priv_t pls, logic sum);
    idle();
    step();
    enable_translation_i   = en_f;
    en_ld_st_translation_i = en_ls;
    priv_lvl_i             = pf;
    ld_st_priv_lvl_i       = pls;
    sum_i                  = sum;
  endtask

  task automatic random_refill(int t, logic own);
    mmu_pkg::tlb_update_t u;
    logic [31:0]          r;
    r         = $urandom;
    u         = '0;
    u.valid   = 1'b1;
    u.is_page = (r[1:0] == 2'b00);
    u.asid    = (own || (r[3:2] != 2'b00)) ? asid_i : asid_i + 9'd1;
    r         = $urandom;
    u.vpn     = r[19:0];
    r         = $urandom;
    u.content = r[29:0];
    u.content.v = 1'b1;
    if (t == 0) itlb_update_i = u;
    else dtlb_update_i = u;
  endtask

  // mapped addresses reuse a model tag, stale tags after a flush included
  function automatic mmu_pkg::vaddr_t pick_vaddr(int t, int mapped_pct);
    mmu_pkg::vaddr_t va;
    int              i;
    va = $urandom;
    i  = $urandom % m_size[t];
    if (($urandom % 100) < mapped_pct) begin
      va[31:22] = m_vpn[t][i][19:10];
      if (!m_page[t][i]) va[21:12] = m_vpn[t][i][9:0];
    end
    return va;
  endfunction

  task automatic drive_random(int mapped_pct, int mis_pct);
    logic [31:0] r;
    idle();
    r                 = $urandom;
    fetch_req_i.req   = (r[1:0] != 2'b00);
    fetch_req_i.vaddr = pick_vaddr(0, mapped_pct);
    lsu_req_i         = (r[3:2] != 2'b00);
    lsu_vaddr_i       = pick_vaddr(1, mapped_pct);
    lsu_is_store_i    = r[4];
    lsu_misaligned_i  = ((r >> 8) % 100) < mis_pct;
    step();
  endtask

  task automatic wait_dtlb_hit();
    mmu_pkg::vaddr_t va;
    int              n;
    idle();
    random_refill(1, 1'b1);
    va = {dtlb_update_i.vpn, 12'h000};
    step();
    idle();
    lsu_req_i   = 1'b1;
    lsu_vaddr_i = va;
    n = 0;
    do begin
      step();
      n++;
    end while (!last_dtlb_hit && (n < 8));
    if (!last_dtlb_hit) begin
      timeouts++;
      $display("timeout: refilled DTLB page never hit after %0d cycles", n);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    logic [31:0] r;
    void'($urandom(38259));
    m_size[0] = `MMU_ITLB_ENTRIES;
    m_size[1] = `MMU_DTLB_ENTRIES;
    model_flush();
    pend = '0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    last_dtlb_hit = 1'b0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    idle();
    enable_translation_i = 1'b0;
    en_ld_st_translation_i = 1'b0;
    priv_lvl_i = `MMU_PRIV_S;
    ld_st_priv_lvl_i = `MMU_PRIV_S;
    sum_i = 1'b0;
    asid_i = 9'h005;
    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    // bare mode
    repeat (40) drive_random(50, 0);

    // refill, then back to back hits
    repeat (5) begin
      idle();
      random_refill(0, 1'b0);
      random_refill(1, 1'b0);
      step();
    end
    set_levels(1'b1, 1'b1, `MMU_PRIV_S, `MMU_PRIV_S, 1'b1);
    repeat (80) drive_random(85, 0);

    // misses, then a flush that beats a refill in the same cycle
    repeat (20) drive_random(0, 0);
    idle();
    flush_tlb_i = 1'b1;
    random_refill(1, 1'b1);
    step();
    repeat (20) drive_random(100, 0);
    wait_dtlb_hit();

    // permission faults
    repeat (8) begin
      r = $urandom;
      set_levels(1'b1, 1'b1, r[0] ? `MMU_PRIV_U : `MMU_PRIV_S,
                 r[1] ? `MMU_PRIV_U : `MMU_PRIV_S, r[2]);
      repeat (3) begin
        idle();
        random_refill(0, 1'b0);
        random_refill(1, 1'b0);
        step();
      end
      repeat (15) drive_random(80, 0);
    end

    // misaligned requests, translated and bare
    repeat (40) drive_random(60, 30);
    set_levels(1'b0, 1'b0, `MMU_PRIV_S, `MMU_PRIV_S, 1'b0);
    repeat (10) drive_random(50, 30);
    idle();
    step();
    step();

    $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
